//--- logic/lcd_pkg.sv
package lcd_pkg;

    localparam int LINE_LEN = 20;
    localparam int TEXT_LEN = 32;

    // PCF8574 pin mapping, P7..P4 carry D7..D4
    typedef struct packed {
        logic [3:0] nibble;
        logic       bl;     // Backlight
        logic       en;     // LCD enable strobe
        logic       rw;
        logic       rs;     // 1 = character data
    } exp_fields_t;

    // Same byte seen as LCD pins or as the raw I2C payload
    typedef union packed {
        logic [7:0]  raw;
        exp_fields_t f;
    } exp_byte_u;

    // Settle time class applied after an item
    typedef enum logic [1:0] {
        wait_data,
        wait_cmd,
        wait_clear
    } wait_class_e;

    typedef struct packed {
        logic        rs;
        logic [7:0]  value;
        wait_class_e wait_sel;
    } lcd_item_t;

    // 4-bit init, 2 lines, display on, entry mode, clear, home
    localparam logic [0:6][7:0] INIT_CMDS = {
        8'h33, 8'h32, 8'h28, 8'h0C, 8'h06, 8'h01, 8'h80
    };

    localparam logic [7:0] LINE2_CMD = 8'hC0;  // DDRAM address 0x40

    localparam logic [0:TEXT_LEN-1][7:0] LCD_TEXT = {
        "    Hello World!    ",
        "  I2C LCD 20"
    };

endpackage

//--- logic/i2c_byte_master.sv
`timescale 1ns/1ps

module i2c_byte_master import lcd_pkg::*; #(
    parameter logic [6:0] I2C_ADDR = 7'h27,
    parameter int         CLK_DIV  = 500
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      start,
    input  exp_byte_u tx_byte,
    output logic      busy,
    output logic      done,
    output logic      scl,
    output logic      sda_out,
    output logic      sda_en
);

    localparam int CNT_W = $clog2(CLK_DIV);

    localparam logic [CNT_W-1:0] QTR       = CNT_W'(CLK_DIV / 4);
    localparam logic [CNT_W-1:0] THREE_QTR = CNT_W'(3 * CLK_DIV / 4);
    localparam logic [CNT_W-1:0] SDA_AT    = CNT_W'(CLK_DIV / 8);  // Well inside SCL low
    localparam logic [CNT_W-1:0] LAST      = CNT_W'(CLK_DIV - 1);

    typedef enum logic [1:0] {
        i2c_idle,
        i2c_start,
        i2c_bits,
        i2c_stop
    } i2c_state_e;

    i2c_state_e       state;
    logic [CNT_W-1:0] cnt;
    logic [3:0]       bit_cnt;   // 8 is the acknowledge slot
    logic             byte_sel;  // 0 address, 1 data
    logic [7:0]       shreg;
    exp_byte_u        data_buf;
    logic             tick_end;

    assign busy     = (state != i2c_idle);
    assign tick_end = (cnt == LAST);

    // Payload shifter
    always_ff @(posedge clk) begin
        if (state == i2c_idle && start) begin
            data_buf <= tx_byte;
            shreg    <= {I2C_ADDR, 1'b0};  // Write frame
        end else if (state == i2c_bits && tick_end) begin
            if (bit_cnt == 4'd8) begin
                shreg <= data_buf.raw;
            end else begin
                shreg <= {shreg[6:0], 1'b0};
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= i2c_idle;
            cnt      <= '0;
            bit_cnt  <= '0;
            byte_sel <= 1'b0;
            scl      <= 1'b1;
            sda_out  <= 1'b1;
            sda_en   <= 1'b1;
            done     <= 1'b0;
        end else begin
            done <= 1'b0;
            cnt  <= tick_end ? '0 : cnt + 1'b1;
            case (state)
                i2c_idle: begin
                    cnt     <= '0;
                    scl     <= 1'b1;
                    sda_out <= 1'b1;
                    sda_en  <= 1'b1;
                    if (start) state <= i2c_start;
                end
                i2c_start: begin
                    if (cnt == QTR) sda_out <= 1'b0;  // SDA falls with SCL high
                    if (tick_end) begin
                        bit_cnt  <= '0;
                        byte_sel <= 1'b0;
                        state    <= i2c_bits;
                    end
                end
                i2c_bits: begin
                    scl <= (cnt >= QTR) && (cnt < THREE_QTR);
                    if (cnt == SDA_AT) begin
                        if (bit_cnt == 4'd8) begin
                            sda_en <= 1'b0;  // Release for the slave ACK
                        end else begin
                            sda_en  <= 1'b1;
                            sda_out <= shreg[7];
                        end
                    end
                    if (tick_end) begin
                        if (bit_cnt == 4'd8) begin
                            bit_cnt <= '0;
                            if (byte_sel) begin
                                state <= i2c_stop;
                            end else begin
                                byte_sel <= 1'b1;
                            end
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                default: begin
                    scl <= (cnt >= QTR);  // SCL stays high into idle
                    if (cnt == SDA_AT) begin
                        sda_en  <= 1'b1;
                        sda_out <= 1'b0;
                    end
                    if (cnt == THREE_QTR) sda_out <= 1'b1;  // Stop condition
                    if (tick_end) begin
                        done  <= 1'b1;
                        state <= i2c_idle;
                    end
                end
            endcase
        end
    end

endmodule

//--- logic/lcd_bus_writer.sv
`timescale 1ns/1ps

module lcd_bus_writer import lcd_pkg::*; #(
    parameter logic [6:0] I2C_ADDR   = 7'h27,
    parameter int         CLK_DIV    = 500,
    parameter int         CMD_WAIT   = 50000,
    parameter int         CLEAR_WAIT = 200000,
    parameter int         DATA_WAIT  = 10000
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      empty,
    input  lcd_item_t pop_item,
    output logic      pop,
    output logic      scl,
    output logic      sda_out,
    output logic      sda_en
);

    localparam int MAX_CD   = (CLEAR_WAIT > CMD_WAIT) ? CLEAR_WAIT : CMD_WAIT;
    localparam int MAX_WAIT = (MAX_CD > DATA_WAIT) ? MAX_CD : DATA_WAIT;
    localparam int WAIT_W   = $clog2(MAX_WAIT + 1);

    typedef enum logic [1:0] {
        bw_idle,
        bw_send,
        bw_wait,
        bw_settle
    } bw_state_e;

    bw_state_e         state;
    lcd_item_t         item;
    logic [1:0]        phase;      // Frame 0..3 within the item
    logic [WAIT_W-1:0] settle_cnt;
    logic [WAIT_W-1:0] settle_load;
    logic              start;
    logic              busy;
    logic              done;
    exp_byte_u         tx_byte;

    assign pop   = (state == bw_idle) && !empty;
    assign start = (state == bw_send) && !busy;

    // Bit 1 of phase picks the nibble, bit 0 drops E
    always_comb begin
        tx_byte.f.nibble = phase[1] ? item.value[3:0] : item.value[7:4];
        tx_byte.f.bl     = 1'b1;
        tx_byte.f.en     = ~phase[0];
        tx_byte.f.rw     = 1'b0;
        tx_byte.f.rs     = item.rs;
    end

    always_comb begin
        case (item.wait_sel)
            wait_clear: settle_load = WAIT_W'(CLEAR_WAIT);
            wait_cmd:   settle_load = WAIT_W'(CMD_WAIT);
            default:    settle_load = WAIT_W'(DATA_WAIT);
        endcase
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            item <= pop_item;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= bw_idle;
            phase      <= '0;
            settle_cnt <= '0;
        end else begin
            case (state)
                bw_idle: begin
                    if (pop) begin
                        phase <= '0;
                        state <= bw_send;
                    end
                end
                bw_send: begin
                    if (start) state <= bw_wait;
                end
                bw_wait: begin
                    if (done) begin
                        if (phase == 2'd3) begin
                            settle_cnt <= settle_load;  // Counted from the last stop
                            state      <= bw_settle;
                        end else begin
                            phase <= phase + 1'b1;
                            state <= bw_send;
                        end
                    end
                end
                default: begin
                    if (settle_cnt == '0) begin
                        state <= bw_idle;
                    end else begin
                        settle_cnt <= settle_cnt - 1'b1;
                    end
                end
            endcase
        end
    end

    i2c_byte_master #(
        .I2C_ADDR (I2C_ADDR),
        .CLK_DIV  (CLK_DIV)
    ) i_i2c_byte_master (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .tx_byte (tx_byte),
        .busy    (busy),
        .done    (done),
        .scl     (scl),
        .sda_out (sda_out),
        .sda_en  (sda_en)
    );

endmodule

//--- logic/lcd_item_fifo.sv
`timescale 1ns/1ps

module lcd_item_fifo import lcd_pkg::*; #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      push,
    input  lcd_item_t push_item,
    input  logic      pop,
    output lcd_item_t pop_item,
    output logic      full,
    output logic      empty
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    lcd_item_t        mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             wr_en;
    logic             rd_en;

    // Wrap explicitly so any depth works
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign wr_en = push && !full;
    assign rd_en = pop && !empty;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= push_item;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) wr_ptr <= next_ptr(wr_ptr);
            if (rd_en) rd_ptr <= next_ptr(rd_ptr);
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;  // Both or neither, level unchanged
            endcase
        end
    end

    assign pop_item = mem[rd_ptr];
    assign full     = (count == CNT_W'(FIFO_DEPTH));
    assign empty    = (count == '0);

endmodule

//--- logic/lcd_sequencer.sv
`timescale 1ns/1ps

module lcd_sequencer import lcd_pkg::*; #(
    parameter int POWERUP_CYCLES = 5000000
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      full,
    output logic      push,
    output lcd_item_t push_item
);

    localparam int INIT_LEN   = $bits(INIT_CMDS) / 8;
    localparam int ITEM_COUNT = INIT_LEN + TEXT_LEN + 1;  // Text plus line-2 command
    localparam int PWR_W      = $clog2(POWERUP_CYCLES + 1);
    localparam int IDX_W      = $clog2(ITEM_COUNT + 1);
    localparam int INIT_W     = $clog2(INIT_LEN);
    localparam int TXT_W      = $clog2(TEXT_LEN);

    localparam logic [IDX_W-1:0] FIRST_CHAR = IDX_W'(INIT_LEN);
    localparam logic [IDX_W-1:0] LINE2_IDX  = IDX_W'(INIT_LEN + LINE_LEN);
    localparam logic [IDX_W-1:0] LAST_IDX   = IDX_W'(ITEM_COUNT - 1);

    typedef enum logic [1:0] {
        seq_wait,
        seq_run,
        seq_done
    } seq_state_e;

    seq_state_e       state;
    logic [PWR_W-1:0] pwr_cnt;
    logic [IDX_W-1:0] idx;
    logic [IDX_W-1:0] text_idx;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= seq_wait;
            pwr_cnt <= '0;
            idx     <= '0;
        end else begin
            case (state)
                seq_wait: begin
                    // LCD controller needs time after power-up
                    if (pwr_cnt == PWR_W'(POWERUP_CYCLES - 1)) begin
                        state <= seq_run;
                    end else begin
                        pwr_cnt <= pwr_cnt + 1'b1;
                    end
                end
                seq_run: begin
                    if (push) begin
                        idx <= idx + 1'b1;
                        if (idx == LAST_IDX) begin
                            state <= seq_done;
                        end
                    end
                end
                default: ;  // Stays silent until reset
            endcase
        end
    end

    assign push = (state == seq_run) && !full;  // Hold place while FIFO is full

    // Skip over the line-2 command slot for the second line
    assign text_idx = (idx < LINE2_IDX) ? idx - FIRST_CHAR : idx - FIRST_CHAR - 1'b1;

    always_comb begin
        push_item.rs       = 1'b1;
        push_item.value    = LCD_TEXT[text_idx[TXT_W-1:0]];
        push_item.wait_sel = wait_data;
        if (idx < FIRST_CHAR) begin
            push_item.rs       = 1'b0;
            push_item.value    = INIT_CMDS[idx[INIT_W-1:0]];
            push_item.wait_sel = (push_item.value == 8'h01) ? wait_clear : wait_cmd;
        end else if (idx == LINE2_IDX) begin
            push_item.rs       = 1'b0;
            push_item.value    = LINE2_CMD;
            push_item.wait_sel = wait_cmd;
        end
    end

endmodule

//--- logic/lcd_i2c_top.sv
`timescale 1ns/1ps

module lcd_i2c_top import lcd_pkg::*; #(
    parameter logic [6:0] I2C_ADDR       = 7'h27,
    parameter int         CLK_DIV        = 500,
    parameter int         POWERUP_CYCLES = 5000000,  // 50 ms at 100 MHz
    parameter int         CMD_WAIT       = 50000,
    parameter int         CLEAR_WAIT     = 200000,
    parameter int         DATA_WAIT      = 10000,
    parameter int         FIFO_DEPTH     = 4
) (
    input  logic clk,
    input  logic rst,
    output logic scl,
    output logic sda_out,
    output logic sda_en
);

    logic      push;
    logic      pop;
    logic      full;
    logic      empty;
    lcd_item_t push_item;
    lcd_item_t pop_item;

    lcd_sequencer #(
        .POWERUP_CYCLES (POWERUP_CYCLES)
    ) i_lcd_sequencer (
        .clk       (clk),
        .rst       (rst),
        .full      (full),
        .push      (push),
        .push_item (push_item)
    );

    lcd_item_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_lcd_item_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (push),
        .push_item (push_item),
        .pop       (pop),
        .pop_item  (pop_item),
        .full      (full),
        .empty     (empty)
    );

    lcd_bus_writer #(
        .I2C_ADDR   (I2C_ADDR),
        .CLK_DIV    (CLK_DIV),
        .CMD_WAIT   (CMD_WAIT),
        .CLEAR_WAIT (CLEAR_WAIT),
        .DATA_WAIT  (DATA_WAIT)
    ) i_lcd_bus_writer (
        .clk      (clk),
        .rst      (rst),
        .empty    (empty),
        .pop_item (pop_item),
        .pop      (pop),
        .scl      (scl),
        .sda_out  (sda_out),
        .sda_en   (sda_en)
    );

endmodule

//--- tests/lcd_i2c_chk.sv
`timescale 1ns/1ps

module lcd_i2c_chk (
    input logic clk,
    input logic rst,
    input logic push,
    input logic full,
    input logic pop,
    input logic empty,
    input logic start,
    input logic busy,
    input logic done
);

    logic push_fired  = 1'b0;
    logic pop_fired   = 1'b0;
    logic done_fired  = 1'b0;
    logic start_fired = 1'b0;
    logic any_fired;

    assign any_fired = push_fired | pop_fired | done_fired | start_fired;

    push_when_full: assert property (@(posedge clk) disable iff (rst) push |-> !full)
        else begin
            $error("FIFO push while full");
            push_fired = 1'b1;
        end

    pop_when_empty: assert property (@(posedge clk) disable iff (rst) pop |-> !empty)
        else begin
            $error("FIFO pop while empty");
            pop_fired = 1'b1;
        end

    // Frame end is a single-cycle pulse
    done_one_cycle: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else begin
            $error("I2C done pulse lasted more than one cycle");
            done_fired = 1'b1;
        end

    start_when_busy: assert property (@(posedge clk) disable iff (rst) start |-> !busy)
        else begin
            $error("I2C start given while the master was busy");
            start_fired = 1'b1;
        end

endmodule

bind lcd_i2c_top lcd_i2c_chk i_lcd_i2c_chk (
    .clk   (clk),
    .rst   (rst),
    .push  (push),
    .full  (full),
    .pop   (pop),
    .empty (empty),
    .start (i_lcd_bus_writer.start),
    .busy  (i_lcd_bus_writer.busy),
    .done  (i_lcd_bus_writer.done)
);

//--- tests/lcd_i2c_tb.sv
`timescale 1ns/1ps

module lcd_i2c_tb import lcd_pkg::*; ();

    localparam logic [6:0] I2C_ADDR       = 7'h27;
    localparam int         CLK_DIV        = 8;
    localparam int         POWERUP_CYCLES = 50;
    localparam int         CMD_WAIT       = 20;
    localparam int         CLEAR_WAIT     = 60;
    localparam int         DATA_WAIT      = 10;
    localparam int         FIFO_DEPTH     = 4;
    localparam int         INIT_LEN       = 7;
    localparam int         ITEM_COUNT     = 40;  // 7 commands, 20 + 12 characters, line-2 cursor
    localparam int         QUIET_CYCLES   = 2000;
    // Twice the bound of 20 bit times per frame plus the longest settle per item
    localparam int         TIMEOUT_CYCLES =
        2 * (POWERUP_CYCLES + ITEM_COUNT * (4 * 20 * CLK_DIV + CLEAR_WAIT));

    typedef struct packed {
        logic       rs;
        logic [7:0] value;
    } ref_item_t;

    typedef struct packed {
        logic [7:0]  data;
        logic [31:0] start_cyc;
        logic [31:0] stop_cyc;
    } frame_rec_t;

    logic        clk;
    logic        rst;
    logic        scl;
    logic        sda_out;
    logic        sda_en;
    logic        sda_lvl;
    logic        prev_scl;
    logic        prev_sda;
    logic        in_frame;
    logic        seen_start;
    logic        items_done;
    logic [17:0] frame_bits;   // Address, ACK, data, ACK
    int unsigned bit_cnt;
    int unsigned cyc_cnt    = 0;
    int unsigned since_rst  = 0;
    int unsigned run_cycles = 0;
    frame_rec_t  cur_frame;
    frame_rec_t  frame_q [$];

    lcd_i2c_top #(
        .I2C_ADDR       (I2C_ADDR),
        .CLK_DIV        (CLK_DIV),
        .POWERUP_CYCLES (POWERUP_CYCLES),
        .CMD_WAIT       (CMD_WAIT),
        .CLEAR_WAIT     (CLEAR_WAIT),
        .DATA_WAIT      (DATA_WAIT),
        .FIFO_DEPTH     (FIFO_DEPTH)
    ) i_lcd_i2c_top (
        .clk     (clk),
        .rst     (rst),
        .scl     (scl),
        .sda_out (sda_out),
        .sda_en  (sda_en)
    );

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_field(input string name, input int item, input int frame,
                               input logic [7:0] got, input logic [7:0] want);
        assert (got == want)
            else stop_on_error($sformatf("Error: %s of item %0d frame %0d = 0x%h, expected 0x%h",
                                         name, item, frame, got, want));
    endtask

    task automatic check_bus_idle();
        assert (scl && sda_out && sda_en)
            else stop_on_error($sformatf("Error: {scl, sda_out, sda_en} = 0x%h, expected 0x7",
                                         {scl, sda_out, sda_en}));
    endtask

    // Item order: init commands, line 1, line-2 cursor, line 2
    function automatic ref_item_t expected_item(input int index);
        ref_item_t r;
        if (index < INIT_LEN) begin
            r.rs    = 1'b0;
            r.value = INIT_CMDS[3'(index)];
        end else if (index < INIT_LEN + LINE_LEN) begin
            r.rs    = 1'b1;
            r.value = LCD_TEXT[5'(index - INIT_LEN)];
        end else if (index == INIT_LEN + LINE_LEN) begin
            r.rs    = 1'b0;
            r.value = LINE2_CMD;
        end else begin
            r.rs    = 1'b1;
            r.value = LCD_TEXT[5'(index - INIT_LEN - 1)];
        end
        return r;
    endfunction

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (8) @(posedge clk);
        #1 rst = 1'b0;
    end

    always @(posedge clk) begin
        run_cycles++;
        if (run_cycles > TIMEOUT_CYCLES) begin
            stop_on_error($sformatf("Timeout after %0d cycles without finishing", run_cycles));
        end
    end

    always @(negedge clk) begin
        assert (!i_lcd_i2c_top.i_lcd_i2c_chk.any_fired)
            else stop_on_error("A bound protocol assertion on the DUT failed");
    end

    // I2C decoder, sampled away from the driving edge
    always @(negedge clk) begin
        sda_lvl = sda_en ? sda_out : 1'b1;  // Released line reads high
        cyc_cnt++;
        if (rst) begin
            check_bus_idle();
            prev_scl   = 1'b1;
            prev_sda   = 1'b1;
            in_frame   = 1'b0;
            seen_start = 1'b0;
            since_rst  = 0;
        end else begin
            since_rst++;
            if (prev_scl && scl && prev_sda && !sda_lvl) begin
                assert (!in_frame) else stop_on_error("Repeated start inside a frame");
                assert (!items_done) else stop_on_error("Start condition after the last item");
                assert (since_rst > POWERUP_CYCLES)
                    else stop_on_error("Start condition during the power-up wait");
                in_frame            = 1'b1;
                seen_start          = 1'b1;
                bit_cnt             = 0;
                cur_frame.start_cyc = cyc_cnt;
            end else if (prev_scl && scl && !prev_sda && sda_lvl) begin
                assert (in_frame) else stop_on_error("Stop condition outside a frame");
                assert (bit_cnt == 19)
                    else stop_on_error($sformatf("Frame ended after %0d SCL pulses", bit_cnt));
                assert (frame_bits[17:10] == {I2C_ADDR, 1'b0})
                    else stop_on_error($sformatf("Error: address byte = 0x%h, expected 0x%h",
                                                 frame_bits[17:10], {I2C_ADDR, 1'b0}));
                cur_frame.data     = frame_bits[8:1];
                cur_frame.stop_cyc = cyc_cnt;
                frame_q.push_back(cur_frame);
                in_frame = 1'b0;
            end else if (!prev_scl && scl) begin
                assert (in_frame && bit_cnt < 19)
                    else stop_on_error("SCL pulse outside the bit slots of a frame");
                // 18 bit slots, then SCL rises once more ahead of the stop
                if (bit_cnt < 18) begin
                    frame_bits = {frame_bits[16:0], sda_lvl};
                end
                bit_cnt++;
            end
            if (!seen_start) check_bus_idle();  // Quiet until the first frame
            prev_scl = scl;
            prev_sda = sda_lvl;
        end
    end

    initial begin : compare_items
        frame_rec_t  grp [4];
        exp_byte_u   fb [4];
        ref_item_t   want;
        logic [31:0] gap;
        logic [31:0] last_stop;
        logic        last_clear;

        items_done = 1'b0;
        last_stop  = '0;
        last_clear = 1'b0;
        for (int i = 0; i < ITEM_COUNT; i++) begin
            for (int k = 0; k < 4; k++) begin
                while (frame_q.size() == 0) @(posedge clk);
                grp[k]    = frame_q.pop_front();
                fb[k].raw = grp[k].data;
            end
            want = expected_item(i);
            for (int k = 0; k < 4; k++) begin
                // bl, en, rw, rs with E high on the first frame of each nibble
                check_field("{bl, en, rw, rs}", i, k,
                            {4'h0, fb[k].f.bl, fb[k].f.en, fb[k].f.rw, fb[k].f.rs},
                            {4'h0, 1'b1, ~k[0], 1'b0, want.rs});
            end
            check_field("nibble", i, 1, {4'h0, fb[1].f.nibble}, {4'h0, fb[0].f.nibble});
            check_field("nibble", i, 3, {4'h0, fb[3].f.nibble}, {4'h0, fb[2].f.nibble});
            check_field("byte", i, 0, {fb[0].f.nibble, fb[2].f.nibble}, want.value);
            if (i > 0) begin
                gap = grp[0].start_cyc - last_stop;
                assert (gap >= (last_clear ? CLEAR_WAIT : DATA_WAIT))
                    else stop_on_error($sformatf(
                        "Error: settle gap before item %0d = 0x%h, expected at least 0x%h",
                        i, gap, last_clear ? CLEAR_WAIT : DATA_WAIT));
            end
            last_stop  = grp[3].stop_cyc;
            last_clear = !want.rs && (want.value == 8'h01);
        end
        items_done = 1'b1;
        repeat (QUIET_CYCLES) @(posedge clk);
        if (frame_q.size() == 0 && !in_frame) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            stop_on_error("Bus traffic after the last item");
        end
    end

endmodule

//--- sources.f
logic/lcd_pkg.sv
logic/i2c_byte_master.sv
logic/lcd_bus_writer.sv
logic/lcd_item_fifo.sv
logic/lcd_sequencer.sv
logic/lcd_i2c_top.sv
tests/lcd_i2c_chk.sv
tests/lcd_i2c_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and judge the run from its log
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert --top-module lcd_i2c_tb \
    -f sources.f -Mdir obj_dir -o lcd_i2c_sim &&
{ ./obj_dir/lcd_i2c_sim +verilator+error+limit+100 > sim.log 2>&1 || true; } &&
cat sim.log &&
! grep -q "\*\*\* FAILED \*\*\*" sim.log &&
grep -q "\*\*\* PASSED \*\*\*" sim.log &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
